//--- logic/eeprom_pkg.sv
package eeprom_pkg;

    // 2 KB device, eight 256-byte blocks
    localparam int ADDR_BITS = 11;
    localparam int DATA_BITS = 8;

    // address bits that ride in the control byte
    localparam int BLOCK_BITS = ADDR_BITS - DATA_BITS;

    localparam logic [3:0] DEVICE_CODE = 4'b1010; // fixed 24Cxx prefix

    localparam int SCL_DIV = 4; // CLK cycles per bus bit, scl toggles every half

endpackage

//--- logic/host_pkg.sv
package host_pkg;

    typedef enum logic {
        OP_WRITE,
        OP_READ
    } op_t;

    // one queued host request
    typedef struct packed {
        op_t                              op;
        logic [eeprom_pkg::ADDR_BITS-1:0] addr;
        logic [eeprom_pkg::DATA_BITS-1:0] data; // ignored for reads
    } request_t;

    localparam int FIFO_DEPTH = 4; // entries per queue

endpackage

//--- logic/fifo_if.sv
interface fifo_if #(
    parameter type item_t = logic [eeprom_pkg::DATA_BITS-1:0]
);
    logic  push;
    item_t wdata;
    logic  full;
    logic  pop;
    logic  empty;
    item_t rdata; // oldest entry while empty is low

    modport writer (
        output push,
        output wdata,
        input  full
    );

    modport store (
        input  push,
        input  wdata,
        input  pop,
        output full,
        output empty,
        output rdata
    );

    modport reader (
        output pop,
        input  empty,
        input  rdata
    );

endinterface

//--- logic/request_capture.sv
module request_capture (
    input  logic                             CLK,
    input  logic                             RESET,
    input  logic                             wr,
    input  logic                             rd,
    input  logic [eeprom_pkg::ADDR_BITS-1:0] addr,
    input  logic [eeprom_pkg::DATA_BITS-1:0] wdata,
    fifo_if.writer                           q,
    output logic                             overrun
);
    import host_pkg::*;

    logic     pend; // a strobe was seen last cycle
    request_t req_r;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            pend <= 1'b0;
        else
            pend <= wr || rd;
    end

    always_ff @(posedge CLK)
    begin
        if (wr || rd)
        begin
            req_r.op   <= wr ? OP_WRITE : OP_READ; // wr wins
            req_r.addr <= addr;
            req_r.data <= wdata;
        end
    end

    assign q.wdata = req_r;
    assign q.push  = pend && !q.full;
    assign overrun = pend && q.full; // request dropped

    // host must not strobe both at once
    assert property (@(posedge CLK) disable iff (RESET) !(wr && rd))
        else $error("%t: wr and rd strobed in the same cycle", $time);

endmodule

//--- logic/transfer_fifo.sv
module transfer_fifo #(
    parameter type item_t = logic [eeprom_pkg::DATA_BITS-1:0]
) (
    input  logic   CLK,
    input  logic   RESET,
    fifo_if.store  q
);
    import host_pkg::*;

    item_t                           mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(FIFO_DEPTH+1)-1:0] count;
    logic                            do_push;
    logic                            do_pop;

    assign q.full  = (count == FIFO_DEPTH);
    assign q.empty = (count == 0);
    assign q.rdata = mem[rd_ptr];

    assign do_push = q.push && !q.full;
    assign do_pop  = q.pop && !q.empty;

    always_ff @(posedge CLK)
    begin
        if (do_push)
            mem[wr_ptr] <= q.wdata;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    assert property (@(posedge CLK) disable iff (RESET) q.push |-> !q.full)
        else $error("%t: push into full queue", $time);

    assert property (@(posedge CLK) disable iff (RESET) q.pop |-> !q.empty)
        else $error("%t: pop from empty queue", $time);

endmodule

//--- logic/serial_engine.sv
module serial_engine (
    input  logic   CLK,
    input  logic   RESET,
    fifo_if.reader req,
    fifo_if.writer rd,
    output logic   scl_low,
    output logic   sda_low,
    input  logic   sda_in,
    output logic   done,
    output logic   nack
);
    import eeprom_pkg::*;
    import host_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_START,
        S_SHIFT,  // byte out plus ack from slave
        S_RSTART,
        S_READ,   // byte in plus master nack
        S_STOP
    } state_t;

    state_t                          state;
    request_t                        cur;
    logic [DATA_BITS-1:0]            sh;
    logic [$clog2(SCL_DIV)-1:0]      phase;
    logic [$clog2(DATA_BITS+1)-1:0]  bit_cnt;
    logic [1:0]                      stage; // 0 ctrl, 1 addr, 2 data, 3 ctrl for reading
    logic                            nack_seen;
    logic                            push_r;
    logic                            bit_end;
    logic                            can_start;

    function automatic logic [DATA_BITS-1:0] ctrl_byte(
        input logic [ADDR_BITS-1:0] a,
        input logic                 rnw
    );
        ctrl_byte = {DEVICE_CODE, a[ADDR_BITS-1 -: BLOCK_BITS], rnw};
    endfunction

    assign bit_end = (phase == SCL_DIV - 1);

    // a read waits for room in rd_q, done cycle lets a pending push settle
    assign can_start = !req.empty && !done && !(req.rdata.op == OP_READ && rd.full);

    assign req.pop  = (state == S_FETCH);
    assign rd.push  = push_r;
    assign rd.wdata = sh;

    always_comb
    begin
        scl_low = 1'b0;
        sda_low = 1'b0;
        case (state)
            S_START:
                sda_low = (phase >= SCL_DIV / 2); // falls with scl high
            S_SHIFT:
            begin
                scl_low = (phase < SCL_DIV / 2);
                sda_low = (bit_cnt != DATA_BITS) && !sh[DATA_BITS-1];
            end
            S_RSTART:
            begin
                scl_low = (phase < SCL_DIV / 2);
                sda_low = bit_end;
            end
            S_READ:
                scl_low = (phase < SCL_DIV / 2); // sda left to slave, then nack
            S_STOP:
            begin
                scl_low = (phase < SCL_DIV / 2);
                sda_low = !bit_end; // rises with scl high
            end
            default:
            begin
                scl_low = 1'b0;
                sda_low = 1'b0;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            phase     <= '0;
            bit_cnt   <= '0;
            stage     <= 2'd0;
            nack_seen <= 1'b0;
            done      <= 1'b0;
            nack      <= 1'b0;
            push_r    <= 1'b0;
        end
        else
        begin
            done   <= 1'b0;
            nack   <= 1'b0;
            push_r <= 1'b0;
            if (state != S_IDLE && state != S_FETCH)
                phase <= phase + 1'b1;
            case (state)
                S_IDLE:
                    if (can_start)
                        state <= S_FETCH;
                S_FETCH:
                begin
                    cur       <= req.rdata;
                    sh        <= ctrl_byte(req.rdata.addr, 1'b0); // dummy write first
                    phase     <= '0;
                    bit_cnt   <= '0;
                    stage     <= 2'd0;
                    nack_seen <= 1'b0;
                    state     <= S_START;
                end
                S_START:
                    if (bit_end)
                        state <= S_SHIFT;
                S_SHIFT:
                    if (bit_end)
                    begin
                        if (bit_cnt != DATA_BITS)
                        begin
                            sh      <= sh << 1;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                        else
                        begin
                            bit_cnt <= '0;
                            if (sda_in)
                            begin
                                nack_seen <= 1'b1; // no ack, straight to stop
                                state     <= S_STOP;
                            end
                            else
                            begin
                                case (stage)
                                    2'd0:
                                    begin
                                        sh    <= cur.addr[DATA_BITS-1:0];
                                        stage <= 2'd1;
                                    end
                                    2'd1:
                                        if (cur.op == OP_READ)
                                            state <= S_RSTART;
                                        else
                                        begin
                                            sh    <= cur.data;
                                            stage <= 2'd2;
                                        end
                                    2'd2:
                                        state <= S_STOP;
                                    default:
                                        state <= S_READ;
                                endcase
                            end
                        end
                    end
                S_RSTART:
                    if (bit_end)
                    begin
                        sh    <= ctrl_byte(cur.addr, 1'b1);
                        stage <= 2'd3;
                        state <= S_SHIFT;
                    end
                S_READ:
                    if (bit_end)
                    begin
                        if (bit_cnt != DATA_BITS)
                        begin
                            sh      <= {sh[DATA_BITS-2:0], sda_in}; // msb first
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                        else
                        begin
                            bit_cnt <= '0;
                            state   <= S_STOP;
                        end
                    end
                S_STOP:
                    if (bit_end)
                    begin
                        done   <= 1'b1;
                        nack   <= nack_seen;
                        push_r <= (cur.op == OP_READ) && !nack_seen;
                        state  <= S_IDLE;
                    end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // data may only move under a low clock, start and stop excepted
    assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_in) |-> scl_low || state inside {S_START, S_RSTART, S_STOP})
        else $error("%t: sda changed while scl high", $time);

    // room in rd_q was checked before the read began
    assert property (@(posedge CLK) disable iff (RESET) rd.push |-> !rd.full)
        else $error("%t: read byte pushed into full rd_q", $time);

endmodule

//--- logic/eeprom_ctrl.sv
module eeprom_ctrl (
    input  logic                             CLK,
    input  logic                             RESET,
    input  logic                             wr,
    input  logic                             rd,
    input  logic [eeprom_pkg::ADDR_BITS-1:0] addr,
    input  logic [eeprom_pkg::DATA_BITS-1:0] wdata,
    input  logic                             rd_pop,
    output logic                             rd_empty,
    output logic [eeprom_pkg::DATA_BITS-1:0] rd_data,
    output logic                             done,
    output logic                             nack,
    output logic                             overrun,
    inout  wire                              scl,
    inout  wire                              sda
);
    import eeprom_pkg::*;
    import host_pkg::*;

    logic scl_low;
    logic sda_low;

    fifo_if #(.item_t(request_t))             req_if ();
    fifo_if #(.item_t(logic [DATA_BITS-1:0])) rd_if ();

    request_capture request_capture_i (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wdata   (wdata),
        .q       (req_if.writer),
        .overrun (overrun)
    );

    transfer_fifo #(.item_t(request_t)) req_q (
        .CLK   (CLK),
        .RESET (RESET),
        .q     (req_if.store)
    );

    transfer_fifo #(.item_t(logic [DATA_BITS-1:0])) rd_q (
        .CLK   (CLK),
        .RESET (RESET),
        .q     (rd_if.store)
    );

    serial_engine serial_engine_i (
        .CLK     (CLK),
        .RESET   (RESET),
        .req     (req_if.reader),
        .rd      (rd_if.writer),
        .scl_low (scl_low),
        .sda_low (sda_low),
        .sda_in  (sda),
        .done    (done),
        .nack    (nack)
    );

    // host pops read bytes directly
    assign rd_if.pop = rd_pop;
    assign rd_empty  = rd_if.empty;
    assign rd_data   = rd_if.rdata;

    // open drain, pull-ups are on the board
    assign scl = scl_low ? 1'b0 : 1'bz;
    assign sda = sda_low ? 1'b0 : 1'bz;

endmodule

//--- test/eeprom_model.sv
module eeprom_model (
    input  logic CLK,
    input  wire  scl,
    inout  wire  sda,
    input  logic refuse // stay silent, never acknowledge
);
    import eeprom_pkg::*;

    typedef enum logic [2:0] {
        M_IDLE,
        M_RX,
        M_ACK,
        M_TX,
        M_WAIT
    } mode_t;

    logic [DATA_BITS-1:0]  mem [2**ADDR_BITS];
    mode_t                 mode;
    logic [DATA_BITS-1:0]  sh;
    logic [3:0]            cnt;
    logic [1:0]            byte_idx; // 0 control, 1 address, 2 data
    logic [BLOCK_BITS-1:0] block;
    logic [ADDR_BITS-1:0]  ptr;
    logic                  reading;
    logic                  pull;
    logic                  prev_scl;
    logic                  prev_sda;

    assign sda = pull ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 2**ADDR_BITS; i++)
            mem[i] = i[7:0] ^ {i[10:8], 5'b10101};
        mode     = M_IDLE;
        sh       = '0;
        cnt      = '0;
        byte_idx = '0;
        block    = '0;
        ptr      = '0;
        reading  = 1'b0;
        pull     = 1'b0;
        prev_scl = 1'b1;
        prev_sda = 1'b1;
    end

    // bus lines oversampled on the system clock
    always @(posedge CLK)
    begin
        prev_scl <= scl;
        prev_sda <= sda;
        if (prev_scl && scl && prev_sda && !sda)
        begin
            mode     <= M_RX; // start or repeated start
            cnt      <= '0;
            byte_idx <= '0;
            pull     <= 1'b0;
        end
        else if (prev_scl && scl && !prev_sda && sda)
        begin
            mode <= M_IDLE; // stop
            pull <= 1'b0;
        end
        else if (!prev_scl && scl)
        begin
            if (mode == M_RX)
            begin
                sh  <= {sh[DATA_BITS-2:0], sda};
                cnt <= cnt + 1'b1;
            end
        end
        else if (prev_scl && !scl)
        begin
            case (mode)
                M_RX:
                    if (cnt == DATA_BITS)
                    begin
                        cnt <= '0;
                        if (byte_idx == 2'd0)
                        begin
                            if (sh[7:4] == DEVICE_CODE && !refuse)
                            begin
                                block    <= sh[3:1];
                                reading  <= sh[0];
                                byte_idx <= 2'd1;
                                pull     <= 1'b1;
                                mode     <= M_ACK;
                            end
                            else
                                mode <= M_IDLE; // not addressed
                        end
                        else if (byte_idx == 2'd1)
                        begin
                            ptr      <= {block, sh};
                            byte_idx <= 2'd2;
                            pull     <= 1'b1;
                            mode     <= M_ACK;
                        end
                        else
                        begin
                            mem[ptr] <= sh;
                            pull     <= 1'b1;
                            mode     <= M_ACK;
                        end
                    end
                M_ACK:
                    if (reading)
                    begin
                        sh   <= mem[ptr];
                        pull <= !mem[ptr][DATA_BITS-1];
                        cnt  <= 4'd1;
                        mode <= M_TX;
                    end
                    else
                    begin
                        pull <= 1'b0;
                        mode <= M_RX;
                    end
                M_TX:
                    if (cnt == DATA_BITS)
                    begin
                        pull <= 1'b0; // master answers, then stop
                        mode <= M_WAIT;
                    end
                    else
                    begin
                        sh   <= sh << 1;
                        pull <= !sh[DATA_BITS-2];
                        cnt  <= cnt + 1'b1;
                    end
                default:
                    pull <= pull;
            endcase
        end
    end

endmodule

//--- test/eeprom_ctrl_tb.sv
module eeprom_ctrl_tb;
    import eeprom_pkg::*;

    localparam int MAX_CYCLES = 7000; // 40 transactions of 160 cycles plus margin

    logic                 CLK;
    logic                 RESET;
    logic                 wr;
    logic                 rd;
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] wdata;
    logic                 rd_pop;
    logic                 rd_empty;
    logic [DATA_BITS-1:0] rd_data;
    logic                 done;
    logic                 nack;
    logic                 overrun;
    logic                 refuse;
    wire                  scl;
    wire                  sda;

    logic [DATA_BITS-1:0] ref_mem [2**ADDR_BITS]; // bytes written so far
    integer               seed;
    int                   errors;
    int                   checks;
    int                   tests;
    int                   cycles = 0;
    int                   done_cnt = 0;
    int                   overrun_cnt = 0;

    pullup (scl);
    pullup (sda);

    eeprom_ctrl eeprom_ctrl_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .rd_pop   (rd_pop),
        .rd_empty (rd_empty),
        .rd_data  (rd_data),
        .done     (done),
        .nack     (nack),
        .overrun  (overrun),
        .scl      (scl),
        .sda      (sda)
    );

    eeprom_model eeprom_model_i (
        .CLK    (CLK),
        .scl    (scl),
        .sda    (sda),
        .refuse (refuse)
    );

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (done)
            done_cnt <= done_cnt + 1;
        if (overrun)
            overrun_cnt <= overrun_cnt + 1;
        if (cycles == MAX_CYCLES)
        begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge CLK);
        #1; // drive and sample just after the edge
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp)
        else
        begin
            $display("error %0t %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic strobe_write(input logic [ADDR_BITS-1:0] a, input logic [DATA_BITS-1:0] d,
                                input logic lands);
        wr    = 1'b1;
        addr  = a;
        wdata = d;
        next_cycle();
        wr = 1'b0;
        if (lands)
            ref_mem[a] = d;
    endtask

    task automatic strobe_read(input logic [ADDR_BITS-1:0] a);
        rd   = 1'b1;
        addr = a;
        next_cycle();
        rd = 1'b0;
    endtask

    task automatic wait_for_done(input logic exp_nack);
        do
            next_cycle();
        while (done !== 1'b1);
        check_value("nack", exp_nack, nack);
    endtask

    task automatic pop_and_compare(input logic [ADDR_BITS-1:0] a);
        while (rd_empty !== 1'b0)
            next_cycle();
        check_value("rd_data", ref_mem[a], rd_data);
        rd_pop = 1'b1;
        next_cycle();
        rd_pop = 1'b0;
    endtask

    task automatic report_test(input string name, input int errors_before, input int exp_done);
        tests++;
        check_value("done count", exp_done, done_cnt);
        $display("test %0d %s: %s", tests, name, (errors == errors_before) ? "ok" : "errors");
    endtask

    initial
    begin
        logic [ADDR_BITS-1:0] a;
        logic [ADDR_BITS-1:0] b;
        logic [DATA_BITS-1:0] base;
        int                   mark;
        seed        = 32'h5b2dcc5d;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        RESET       = 1'b1;
        wr          = 1'b0;
        rd          = 1'b0;
        addr        = '0;
        wdata       = '0;
        rd_pop      = 1'b0;
        refuse      = 1'b0;
        repeat (4) @(posedge CLK);
        #1;
        RESET = 1'b0;

        mark = errors;
        next_cycle();
        check_value("scl", 1, scl);
        check_value("sda", 1, sda);
        check_value("done", 0, done);
        check_value("nack", 0, nack);
        check_value("overrun", 0, overrun);
        check_value("rd_empty", 1, rd_empty);
        report_test("reset state", mark, 0);

        mark = errors;
        a = $random(seed);
        strobe_write(a, $random(seed), 1'b1);
        wait_for_done(1'b0);
        strobe_read(a);
        wait_for_done(1'b0);
        pop_and_compare(a);
        report_test("write then read", mark, 2);

        // same low byte in every block
        mark = errors;
        b    = $random(seed);
        base = $random(seed);
        for (int blk = 0; blk < 8; blk++)
        begin
            strobe_write({blk[2:0], b[7:0]}, base + blk * 37, 1'b1);
            wait_for_done(1'b0);
        end
        for (int blk = 0; blk < 8; blk++)
        begin
            strobe_read({blk[2:0], b[7:0]});
            wait_for_done(1'b0);
            pop_and_compare({blk[2:0], b[7:0]});
        end
        report_test("block bits", mark, 18);

        mark = errors;
        a = $random(seed);
        b = a ^ 11'h555;
        strobe_write(a, $random(seed), 1'b1);
        strobe_write(b, $random(seed), 1'b1);
        strobe_read(a);
        strobe_read(b);
        repeat (4) wait_for_done(1'b0);
        pop_and_compare(a);
        pop_and_compare(b);
        check_value("overrun count", 0, overrun_cnt);
        report_test("back to back", mark, 22);

        // engine holds one and the queue four so the sixth strobe is dropped
        mark = errors;
        a = $random(seed);
        strobe_write(a, $random(seed), 1'b1);
        wait_for_done(1'b0);
        for (int i = 1; i <= 5; i++)
            strobe_write(a + i, $random(seed), 1'b1);
        strobe_write(a, ~ref_mem[a], 1'b0);
        repeat (5) wait_for_done(1'b0);
        check_value("overrun count", 1, overrun_cnt);
        strobe_read(a);
        wait_for_done(1'b0);
        pop_and_compare(a);
        report_test("overrun", mark, 29);

        mark = errors;
        refuse = 1'b1;
        strobe_write(a, ~ref_mem[a], 1'b0);
        wait_for_done(1'b1);
        strobe_read(a);
        wait_for_done(1'b1);
        repeat (4) next_cycle();
        check_value("rd_empty", 1, rd_empty);
        refuse = 1'b0;
        strobe_read(a); // old byte still there
        wait_for_done(1'b0);
        pop_and_compare(a);
        report_test("no acknowledge", mark, 32);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- build.f
logic/eeprom_pkg.sv
logic/host_pkg.sv
logic/fifo_if.sv
logic/request_capture.sv
logic/transfer_fifo.sv
logic/serial_engine.sv
logic/eeprom_ctrl.sv
test/eeprom_model.sv
test/eeprom_ctrl_tb.sv

//--- Bender.yml
package:
  name: eeprom_ctrl

sources:
  - files:
      - logic/eeprom_pkg.sv
      - logic/host_pkg.sv
      - logic/fifo_if.sv
      - logic/request_capture.sv
      - logic/transfer_fifo.sv
      - logic/serial_engine.sv
      - logic/eeprom_ctrl.sv
  - target: test
    files:
      - test/eeprom_model.sv
      - test/eeprom_ctrl_tb.sv
